// ==== dv/periph_cases.txt ====
// op size addr data expect, all hex; size 0 byte, 1 half, 2 word
// op 1 write, 2 read, 3 read input, 4 pins, 5 irqs, 6 new input, 7 read then new input, 0 end
4 0 000 00000000 00000000
5 0 000 00000000 00000000
1 0 040 000000a5 00000000
4 0 000 00000000 000000a5
2 2 040 00000000 000000a5
6 0 000 00000000 00000000
3 2 044 00000000 00000000
1 0 400 0000006c 00000000
1 2 064 00000010 00000000
1 2 06c 00000010 00000000
1 2 078 00000010 00000000
4 0 000 00000000 000000ef
2 0 401 00000000 0000005a
2 2 064 00000000 00000010
1 2 080 11223344 00000000
5 0 000 00000000 00000004
1 0 080 aabbccdd 00000000
2 2 080 00000000 112233dd
5 0 000 00000000 00000000
1 1 080 99887766 00000000
5 0 000 00000000 00000004
2 2 084 00000000 00000001
2 2 080 00000000 11227766
2 2 084 00000000 00000000
1 2 060 00000002 00000000
4 0 000 00000000 000000ee
2 0 450 00000000 00000000
6 0 000 00000000 00000000
7 2 044 00000000 00000000
0 0 000 00000000 00000000

// ==== tb.f ====
source/tqv_periph_pkg.sv
source/periph_bus_if.sv
source/periph_bus_ctrl.sv
source/gpio_ctrl.sv
source/mailbox_periph.sv
source/gray_coder_periph.sv
source/tqv_peripherals.sv
dv/periph_checker.sv
dv/tb_top.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_top
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_top.sv ====
// Testbench top for the peripheral wrapper
// Replays the case file on the bus and hands each expected value to the checker
`timescale 1ns/1ps
`default_nettype none

module tb_top import tqv_periph_pkg::*; ();

    logic                 clk;
    logic                 rst_n;
    logic [PIN_W-1:0]     ui_in;
    logic [ADDR_W-1:0]    addr;
    logic [DATA_W-1:0]    data;
    logic [1:0]           write_n;
    logic [1:0]           read_n;
    logic                 read_complete;
    logic [PIN_W-1:0]     uo_out;
    logic [DATA_W-1:0]    rd_data;
    logic                 data_ready;
    logic [NUM_SLOTS-1:0] user_irq;

    logic                 chk_valid;
    logic [2:0]           chk_kind;  // 1 data, 2 pins, 3 irqs, 4 ready, 5 timeout
    logic [15:0]          case_num;
    logic [DATA_W-1:0]    chk_exp;
    logic                 chk_done;
    int                   fail_count;

    logic [31:0]          cases [0:319];  // Five words per case
    logic [31:0]          lcg_state;

    tqv_peripherals u_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .i_addr               (addr),
        .i_data               (data),
        .i_data_write_n       (write_n),
        .i_data_read_n        (read_n),
        .i_data_read_complete (read_complete),
        .o_uo_out             (uo_out),
        .o_data               (rd_data),
        .o_data_ready         (data_ready),
        .o_user_interrupts    (user_irq)
    );

    periph_checker u_chk (
        .clk               (clk),
        .i_uo_out          (uo_out),
        .i_data            (rd_data),
        .i_data_ready      (data_ready),
        .i_user_interrupts (user_irq),
        .i_chk_valid       (chk_valid),
        .i_chk_kind        (chk_kind),
        .i_case_num        (case_num),
        .i_chk_exp         (chk_exp),
        .i_done            (chk_done),
        .o_fail_count      (fail_count)
    );

    always #50 clk = ~clk;  // 100 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic new_input();
        lcg_state = lcg_next(lcg_state);
        ui_in     = lcg_state[23:16];  // Upper bits of the LCG are less regular
    endtask

    task automatic check(input logic [2:0] kind, input logic [DATA_W-1:0] exp);
        chk_valid = 1'b1;
        chk_kind  = kind;
        chk_exp   = exp;
        next_cycle();
        chk_valid = 1'b0;
    endtask

    task automatic bus_write(input logic [1:0] size, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] d);
        addr    = a;
        data    = d;
        write_n = size;
        check(3'd4, 32'd1);  // Ready must show in the write cycle itself
        write_n = XFER_NONE;
    endtask

    task automatic start_read(input logic [1:0] size, input logic [ADDR_W-1:0] a,
                              output logic ok);
        int cycles;
        addr   = a;
        read_n = size;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < 20) begin
            next_cycle();
            ok = data_ready;
            cycles++;
        end
        if (!ok) begin
            read_n = XFER_NONE;
            check(3'd5, '0);
        end
    endtask

    task automatic finish_read(input logic [DATA_W-1:0] exp);
        read_n        = XFER_NONE;
        read_complete = 1'b1;
        check(3'd1, exp);
        read_complete = 1'b0;
    endtask

    initial begin
        logic [31:0]       op;
        logic [DATA_W-1:0] held;
        logic              ok;
        clk           = 1'b0;
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        data          = '0;
        write_n       = XFER_NONE;
        read_n        = XFER_NONE;
        read_complete = 1'b0;
        chk_valid     = 1'b0;
        chk_kind      = '0;
        case_num      = '0;
        chk_exp       = '0;
        chk_done      = 1'b0;
        lcg_state     = 32'h7c6e;
        $readmemh("dv/periph_cases.txt", cases);
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        check(3'd4, 32'd0);  // No read result pending after reset

        for (int n = 0; n < 64; n++) begin
            op = cases[5*n];
            if (op == 32'd0) break;
            case_num = 16'(n);
            case (op[3:0])
                4'd1: bus_write(cases[5*n+1][1:0], cases[5*n+2][ADDR_W-1:0], cases[5*n+3]);
                4'd2: begin
                    start_read(cases[5*n+1][1:0], cases[5*n+2][ADDR_W-1:0], ok);
                    if (ok) finish_read(cases[5*n+4]);
                end
                4'd3: begin
                    start_read(cases[5*n+1][1:0], cases[5*n+2][ADDR_W-1:0], ok);
                    if (ok) finish_read({{(DATA_W-PIN_W){1'b0}}, ui_in});
                end
                4'd4: check(3'd2, cases[5*n+4]);
                4'd5: check(3'd3, cases[5*n+4]);
                4'd6: new_input();
                4'd7: begin
                    start_read(cases[5*n+1][1:0], cases[5*n+2][ADDR_W-1:0], ok);
                    if (ok) begin
                        held = {{(DATA_W-PIN_W){1'b0}}, ui_in};
                        new_input();
                        if (ui_in == held[PIN_W-1:0]) ui_in = ~ui_in;
                        next_cycle();  // Let the new pins reach the GPIO read mux
                        finish_read(held);
                    end
                end
                default: check(3'd6, op);
            endcase
        end

        chk_done = 1'b1;
        next_cycle();
        chk_done = 1'b0;
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/periph_checker.sv ====
// Result checker for the peripheral wrapper testbench
// Compares DUT outputs with the expected value of each case and keeps the counts
`timescale 1ns/1ps
`default_nettype none

module periph_checker import tqv_periph_pkg::*; (
    input  wire logic                 clk,
    input  wire logic [PIN_W-1:0]     i_uo_out,
    input  wire logic [DATA_W-1:0]    i_data,
    input  wire logic                 i_data_ready,
    input  wire logic [NUM_SLOTS-1:0] i_user_interrupts,
    input  wire logic                 i_chk_valid,
    input  wire logic [2:0]           i_chk_kind,
    input  wire logic [15:0]          i_case_num,
    input  wire logic [DATA_W-1:0]    i_chk_exp,
    input  wire logic                 i_done,
    output      int                   o_fail_count
);

    int pass_count = 0;
    int fail_count = 0;

    task automatic compare(input string name, input logic [DATA_W-1:0] got);
        if (got === i_chk_exp) begin
            pass_count++;
            $display("case %0d passed, %s = 0x%h", i_case_num, name, got);
        end else begin
            fail_count++;
            $display("mismatch at time %0t, case %0d, %s expected 0x%h, got 0x%h",
                     $time, i_case_num, name, i_chk_exp, got);
        end
    endtask

    // Falling edge sits mid-cycle, well away from input changes
    always @(negedge clk) begin
        if (i_chk_valid) begin
            case (i_chk_kind)
                3'd1: compare("o_data", i_data);
                3'd2: compare("o_uo_out", {{(DATA_W-PIN_W){1'b0}}, i_uo_out});
                3'd3: compare("o_user_interrupts",
                              {{(DATA_W-NUM_SLOTS){1'b0}}, i_user_interrupts});
                3'd4: compare("o_data_ready", {{(DATA_W-1){1'b0}}, i_data_ready});
                3'd5: begin
                    fail_count++;
                    $display("case %0d failed, o_data_ready did not rise within 20 cycles",
                             i_case_num);
                end
                default: begin
                    fail_count++;
                    $display("case %0d failed, unknown operation %0d in the case file",
                             i_case_num, i_chk_exp);
                end
            endcase
        end
        if (i_done) begin
            $display("checks done, %0d passed, %0d failed", pass_count, fail_count);
        end
    end

    assign o_fail_count = fail_count;

endmodule

`default_nettype wire

// ==== source/tqv_peripherals.sv ====
// Peripheral wrapper top level
// Connects the bus controller to the GPIO block, the mailbox and the Gray coder.
// Empty slots read zero and drive no pins.
`timescale 1ns/1ps
`default_nettype none

module tqv_peripherals import tqv_periph_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic [PIN_W-1:0]     i_ui_in,
    input  wire logic [ADDR_W-1:0]    i_addr,
    input  wire logic [DATA_W-1:0]    i_data,
    input  wire logic [1:0]           i_data_write_n,
    input  wire logic [1:0]           i_data_read_n,
    input  wire logic                 i_data_read_complete,
    output      logic [PIN_W-1:0]     o_uo_out,
    output      logic [DATA_W-1:0]    o_data,
    output      logic                 o_data_ready,
    output      logic [NUM_SLOTS-1:0] o_user_interrupts
);

    user_bus_if user_if   [NUM_SLOTS] ();
    byte_bus_if simple_if [NUM_SLOTS] ();

    logic [PIN_W-1:0] user_uo   [NUM_SLOTS];
    logic [PIN_W-1:0] simple_uo [NUM_SLOTS];
    logic             mbox_irq;

    for (genvar k = 0; k < NUM_SLOTS; k++) begin : g_slot
        assign user_uo[k]   = user_if[k].uo;
        assign simple_uo[k] = simple_if[k].uo;

        if (k != SLOT_GPIO && k != SLOT_MAILBOX) begin : g_user_empty
            assign user_if[k].rdata = '0;
            assign user_if[k].ready = 1'b0;  // Never completes a read
            assign user_if[k].uo    = '0;
        end
        if (k != SLOT_GRAY) begin : g_simple_empty
            assign simple_if[k].rdata = '0;
            assign simple_if[k].uo    = '0;
        end
    end

    periph_bus_ctrl u_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_data               (i_data),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready),
        .user_bus             (user_if),
        .simple_bus           (simple_if)
    );

    gpio_ctrl u_gpio (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ui_in     (i_ui_in),
        .bus         (user_if[SLOT_GPIO]),
        .i_user_uo   (user_uo),
        .i_simple_uo (simple_uo),
        .o_uo_out    (o_uo_out)
    );

    mailbox_periph u_mailbox (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (user_if[SLOT_MAILBOX]),
        .o_interrupt (mbox_irq)
    );

    gray_coder_periph u_gray (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (simple_if[SLOT_GRAY])
    );

    // Interrupt line number matches the slot number
    assign o_user_interrupts = {{(NUM_SLOTS-1){1'b0}}, mbox_irq} << SLOT_MAILBOX;

endmodule

`default_nettype wire

// ==== source/gray_coder_periph.sv ====
// Gray coder in simple slot 0
// Stores one byte and offers its Gray code on read and to the pins
`timescale 1ns/1ps
`default_nettype none

module gray_coder_periph import tqv_periph_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    byte_bus_if.device bus
);

    logic [7:0] value;
    logic [7:0] gray;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value <= '0;
        end else if (bus.wr && bus.offset == 4'h0) begin
            value <= bus.wdata;
        end
    end

    assign gray = value ^ (value >> 1);

    always_comb begin
        case (bus.offset)
            4'h0:    bus.rdata = value;
            4'h1:    bus.rdata = gray;
            default: bus.rdata = 8'h00;
        endcase
    end

    // Only the low PIN_W bits of the code reach the pins
    assign bus.uo = gray[PIN_W-1:0];

endmodule

`default_nettype wire

// ==== source/mailbox_periph.sv ====
// Mailbox in user slot 2
// Sized writes merge into a 32-bit word and raise the interrupt,
// a read of the word clears it again
`timescale 1ns/1ps
`default_nettype none

module mailbox_periph import tqv_periph_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    user_bus_if.device bus,
    output      logic  o_interrupt
);

    logic [DATA_W-1:0] mbox_data;
    logic              irq;
    logic [3:0]        lane_en;
    logic              data_sel;
    logic              wr_en;
    logic              rd_en;

    assign data_sel = bus.offset == MBOX_DATA_OFS;
    assign wr_en    = bus.write_n != XFER_NONE;
    assign rd_en    = bus.read_n != XFER_NONE;

    // Low lanes written by each size
    always_comb begin
        case (bus.write_n)
            XFER_BYTE: lane_en = 4'b0001;
            XFER_HALF: lane_en = 4'b0011;
            XFER_WORD: lane_en = 4'b1111;
            default:   lane_en = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (data_sel) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_en[b]) mbox_data[8*b +: 8] <= bus.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else if (data_sel && wr_en) begin
            irq <= 1'b1;
        end else if (data_sel && rd_en) begin
            irq <= 1'b0;  // Controller masks repeats, so this is the one read
        end
    end

    assign bus.rdata = data_sel                      ? mbox_data :
                       (bus.offset == MBOX_STAT_OFS) ? {{(DATA_W-1){1'b0}}, irq} :
                                                       '0;
    assign bus.ready   = 1'b1;
    assign bus.uo      = mbox_data[PIN_W-1:0];
    assign o_interrupt = irq;

endmodule

`default_nettype wire

// ==== source/gpio_ctrl.sv ====
// GPIO block in user slot 1
// Output register, input pin read and a function select per output pin.
// Each pin takes its bit from the user or simple slot its select names.
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl import tqv_periph_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic [PIN_W-1:0] i_ui_in,
    user_bus_if.device            bus,
    input  wire logic [PIN_W-1:0] i_user_uo   [NUM_SLOTS],
    input  wire logic [PIN_W-1:0] i_simple_uo [NUM_SLOTS],
    output      logic [PIN_W-1:0] o_uo_out
);

    logic [PIN_W-1:0]  gpio_out;
    logic [FSEL_W-1:0] fsel [PIN_W];
    logic              wr_en;
    logic              fsel_hit;
    logic [2:0]        fsel_idx;

    assign wr_en = bus.write_n != XFER_NONE;

    // Word-aligned offsets 0x20 to 0x3c
    assign fsel_hit = (bus.offset & 6'h23) == GPIO_FSEL_BASE;
    assign fsel_idx = bus.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int i = 0; i < PIN_W; i++) begin
                fsel[i] <= {1'b0, SLOT_GPIO};  // Every pin starts on GPIO
            end
        end else if (wr_en) begin
            if (bus.offset == GPIO_OUT_OFS) gpio_out <= bus.wdata[PIN_W-1:0];
            if (fsel_hit) fsel[fsel_idx] <= bus.wdata[FSEL_W-1:0];
        end
    end

    always_comb begin
        if (bus.offset == GPIO_OUT_OFS) begin
            bus.rdata = {{(DATA_W-PIN_W){1'b0}}, gpio_out};
        end else if (bus.offset == GPIO_IN_OFS) begin
            bus.rdata = {{(DATA_W-PIN_W){1'b0}}, i_ui_in};
        end else if (fsel_hit) begin
            bus.rdata = {{(DATA_W-FSEL_W){1'b0}}, fsel[fsel_idx]};
        end else begin
            bus.rdata = '0;
        end
    end

    assign bus.ready = 1'b1;
    assign bus.uo    = gpio_out;  // Seen by the pin mux as user slot 1

    // Per-pin output mux
    for (genvar i = 0; i < PIN_W; i++) begin : g_pin
        logic [3:0] src_slot;

        assign src_slot = fsel[i][3:0];

        always_comb begin
            if (fsel[i][FSEL_W-1]) begin
                o_uo_out[i] = i_simple_uo[src_slot][i];
            end else begin
                o_uo_out[i] = i_user_uo[src_slot][i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/periph_bus_ctrl.sv ====
// Peripheral bus controller
// Decodes the address into one user or simple slot, gates the requests to it,
// muxes its read data and registers the result until the core completes the read
`timescale 1ns/1ps
`default_nettype none

module periph_bus_ctrl import tqv_periph_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [ADDR_W-1:0] i_addr,
    input  wire logic [DATA_W-1:0] i_data,
    input  wire logic [1:0]        i_data_write_n,
    input  wire logic [1:0]        i_data_read_n,
    input  wire logic              i_data_read_complete,
    output      logic [DATA_W-1:0] o_data,
    output      logic              o_data_ready,
    user_bus_if.host               user_bus   [NUM_SLOTS],
    byte_bus_if.host               simple_bus [NUM_SLOTS]
);

    periph_addr_u      addr;
    logic              is_simple;
    logic              read_req;
    logic              write_req;
    logic [1:0]        read_n_masked;
    logic [DATA_W-1:0] user_rdata   [NUM_SLOTS];
    logic              user_ready   [NUM_SLOTS];
    logic [7:0]        simple_rdata [NUM_SLOTS];
    logic [DATA_W-1:0] periph_data;
    logic              periph_ready;
    logic [DATA_W-1:0] data_r;
    logic              data_hold;
    logic              data_ready_r;

    assign addr      = i_addr;
    assign is_simple = addr.user.grp;
    assign read_req  = i_data_read_n != XFER_NONE;
    assign write_req = i_data_write_n != XFER_NONE;

    // Hide the read from the slot while the result waits in data_r
    assign read_n_masked = i_data_read_n | {2{data_ready_r}};

    for (genvar k = 0; k < NUM_SLOTS; k++) begin : g_slot
        logic user_sel;
        logic simple_sel;

        assign user_sel   = !is_simple && addr.user.slot == k;
        assign simple_sel = is_simple && addr.simple.slot == k;

        assign user_bus[k].offset  = addr.user.ofs;
        assign user_bus[k].wdata   = i_data;
        assign user_bus[k].write_n = user_sel ? i_data_write_n : XFER_NONE;
        assign user_bus[k].read_n  = user_sel ? read_n_masked : XFER_NONE;
        assign user_rdata[k]       = user_bus[k].rdata;
        assign user_ready[k]       = user_bus[k].ready;

        assign simple_bus[k].offset = addr.simple.ofs;
        assign simple_bus[k].wr     = simple_sel && write_req;
        assign simple_bus[k].wdata  = i_data[7:0];
        assign simple_rdata[k]      = simple_bus[k].rdata;
    end

    always_comb begin
        if (is_simple) begin
            periph_data  = {{(DATA_W-8){1'b0}}, simple_rdata[addr.simple.slot]};
            periph_ready = 1'b1;  // Simple slots answer at once
        end else begin
            periph_data  = user_rdata[addr.user.slot];
            periph_ready = user_ready[addr.user.slot];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold    <= 1'b0;
            data_ready_r <= 1'b0;
        end else begin
            if (i_data_read_complete) data_hold <= 1'b0;
            if (!data_hold && periph_ready && read_req) data_hold <= 1'b1;
            data_ready_r <= read_req && periph_ready;
        end
    end

    // First result of a read is kept until read complete
    always_ff @(posedge clk) begin
        if (!data_hold && periph_ready && read_req) data_r <= periph_data;
    end

    assign o_data       = data_r;
    assign o_data_ready = data_ready_r || write_req;  // Writes finish in their own cycle

endmodule

`default_nettype wire

// ==== source/periph_bus_if.sv ====
// Peripheral slot interfaces
// user_bus_if serves the 64-byte user slots, byte_bus_if the 16-byte simple slots
`timescale 1ns/1ps
`default_nettype none

interface user_bus_if import tqv_periph_pkg::*; ();
    logic [5:0]        offset;
    logic [DATA_W-1:0] wdata;
    logic [1:0]        write_n;  // XFER_NONE unless this slot is addressed
    logic [1:0]        read_n;
    logic [DATA_W-1:0] rdata;
    logic              ready;
    logic [PIN_W-1:0]  uo;       // Pin byte offered to the output mux

    modport host   (output offset, wdata, write_n, read_n, input rdata, ready, uo);
    modport device (input offset, wdata, write_n, read_n, output rdata, ready, uo);
endinterface

interface byte_bus_if import tqv_periph_pkg::*; ();
    logic [3:0]       offset;
    logic             wr;        // Write strobe, one cycle per write
    logic [7:0]       wdata;
    logic [7:0]       rdata;
    logic [PIN_W-1:0] uo;

    modport host   (output offset, wr, wdata, input rdata, uo);
    modport device (input offset, wr, wdata, output rdata, uo);
endinterface

`default_nettype wire

// ==== source/tqv_periph_pkg.sv ====
// Peripheral wrapper definitions
// Address map, slot numbers, transfer-size codes and the bus address view
`default_nettype none

package tqv_periph_pkg;

    localparam int ADDR_W    = 11;
    localparam int DATA_W    = 32;
    localparam int PIN_W     = 8;
    localparam int NUM_SLOTS = 16;
    localparam int FSEL_W    = 5;  // Bit 4 picks the simple group, bits 3:0 the slot

    // Size codes on the read_n and write_n lines
    localparam logic [1:0] XFER_BYTE = 2'b00;
    localparam logic [1:0] XFER_HALF = 2'b01;
    localparam logic [1:0] XFER_WORD = 2'b10;
    localparam logic [1:0] XFER_NONE = 2'b11;  // Idle

    localparam logic [3:0] SLOT_GPIO    = 4'd1;  // User group
    localparam logic [3:0] SLOT_MAILBOX = 4'd2;  // User group
    localparam logic [3:0] SLOT_GRAY    = 4'd0;  // Simple group

    // GPIO register offsets
    localparam logic [5:0] GPIO_OUT_OFS   = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS    = 6'h04;
    localparam logic [5:0] GPIO_FSEL_BASE = 6'h20;  // Eight selects, one word each

    // Mailbox register offsets
    localparam logic [5:0] MBOX_DATA_OFS = 6'h00;
    localparam logic [5:0] MBOX_STAT_OFS = 6'h04;

    // Bus address seen as a user slot access or as a simple slot access
    typedef union packed {
        struct packed {
            logic       grp;     // 0 for user slots
            logic [3:0] slot;
            logic [5:0] ofs;
        } user;
        struct packed {
            logic       grp;     // 1 for simple slots
            logic [1:0] unused;
            logic [3:0] slot;
            logic [3:0] ofs;
        } simple;
    } periph_addr_u;

endpackage

`default_nettype wire
